// File: verilog/mult_pkg.sv
/* widths, opcode match constants and result-select codes of the
   multiply pipe, plus the product word with its two views */

package mult_pkg;

  // -------------------------------------------------
  // widths
  // -------------------------------------------------
  localparam int xlen   = 64;
  localparam int ext_w  = 65;
  localparam int prod_w = 128;
  localparam int preg_w = 7;
  localparam int iid_w  = 7;
  localparam int dreg_w = 5;
  localparam int op_w   = 17;

  // -------------------------------------------------
  // major opcode, matched against opcode bits 31:15
  // -------------------------------------------------
  localparam logic [op_w-1:0] op_mul_w     = 17'h00038;
  localparam logic [op_w-1:0] op_mulh_w    = 17'h00039;
  localparam logic [op_w-1:0] op_mulh_wu   = 17'h0003a;
  localparam logic [op_w-1:0] op_mul_d     = 17'h0003b;
  localparam logic [op_w-1:0] op_mulh_d    = 17'h0003c;
  localparam logic [op_w-1:0] op_mulh_du   = 17'h0003d;
  localparam logic [op_w-1:0] op_mulw_d_w  = 17'h0003e;
  localparam logic [op_w-1:0] op_mulw_d_wu = 17'h0003f;

  // -------------------------------------------------
  // result select, picked at ex4
  // -------------------------------------------------
  // low doubleword of the product
  localparam logic [1:0] sel_lo64 = 2'b00;
  // high doubleword of the product
  localparam logic [1:0] sel_hi64 = 2'b01;
  // word 0, sign-extended to xlen
  localparam logic [1:0] sel_lo32 = 2'b10;
  // word 1, sign-extended to xlen
  localparam logic [1:0] sel_hi32 = 2'b11;

  // -------------------------------------------------
  // product word
  // -------------------------------------------------
  // dw[1] is the high doubleword, dw[0] the low one;
  // w[3:0] are the 32-bit words from high to low
  typedef union packed {
    logic [1:0][xlen-1:0] dw;
    logic [3:0][31:0]     w;
  } mult_prod_u;

endpackage

// File: verilog/mult_operand_prep.sv
/* opcode decode, 65-bit operand extension and the ex1 operand
   registers of the multiply pipe */

`timescale 1ns/1ps

module mult_operand_prep
  import mult_pkg::*;
(
  input  logic              mult_clk,
  input  logic              cpurst_b,
  input  logic              issue_vld,
  input  logic              flush,
  input  logic [31:0]       issue_opcode,
  input  logic [xlen-1:0]   issue_src0,
  input  logic [xlen-1:0]   issue_src1,
  output logic [ext_w-1:0]  src0_ex1,
  output logic [ext_w-1:0]  src1_ex1,
  output logic [dreg_w-1:0] dreg,
  output logic [1:0]        rslt_sel,
  output logic              accept
);

  logic [op_w-1:0] op_fld;
  logic [7:0]      op_hit;
  logic            use_dw;
  logic            sext_w;
  logic            sign63;
  logic [ext_w-1:0] src0_ext;
  logic [ext_w-1:0] src1_ext;

  // same extension rule for both sources
  function automatic logic [ext_w-1:0] ext_operand(
    input logic [xlen-1:0] src,
    input logic            dw,
    input logic            sx,
    input logic            s63
  );
    logic [31:0] upper;
    logic        sign;
    upper = dw ? src[63:32] : (sx ? {32{src[31]}} : 32'b0);
    sign  = s63 ? src[63] : (sx ? src[31] : 1'b0);
    return {sign, upper, src[31:0]};
  endfunction

  // -------------------------------------------------
  // decode
  // -------------------------------------------------
  assign op_fld = issue_opcode[31:15];

  assign op_hit[0] = (op_fld == op_mul_w);
  assign op_hit[1] = (op_fld == op_mulh_w);
  assign op_hit[2] = (op_fld == op_mulh_wu);
  assign op_hit[3] = (op_fld == op_mul_d);
  assign op_hit[4] = (op_fld == op_mulh_d);
  assign op_hit[5] = (op_fld == op_mulh_du);
  assign op_hit[6] = (op_fld == op_mulw_d_w);
  assign op_hit[7] = (op_fld == op_mulw_d_wu);

  // upper half straight from the source
  assign use_dw = op_hit[3] | op_hit[4] | op_hit[5];
  // signed word forms replicate bit 31
  assign sext_w = op_hit[1] | op_hit[6];
  // sign bit taken from bit 63
  assign sign63 = op_hit[0] | op_hit[3] | op_hit[4];

  assign src0_ext = ext_operand(issue_src0, use_dw, sext_w, sign63);
  assign src1_ext = ext_operand(issue_src1, use_dw, sext_w, sign63);

  always_comb begin
    if (op_hit[0]) begin
      rslt_sel = sel_lo32;
    end else if (op_hit[1] | op_hit[2]) begin
      rslt_sel = sel_hi32;
    end else if (op_hit[4] | op_hit[5]) begin
      rslt_sel = sel_hi64;
    end else begin
      rslt_sel = sel_lo64;
    end
  end

  assign dreg   = issue_opcode[4:0];
  assign accept = issue_vld & ~flush;

  // -------------------------------------------------
  // ex1 operands
  // -------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      src0_ex1 <= '0;
      src1_ex1 <= '0;
    end else if (accept) begin
      src0_ex1 <= src0_ext;
      src1_ex1 <= src1_ext;
    end
  end

  // issuer only sends the eight multiply opcodes here
  a_op_onehot: assert property (
    @(posedge mult_clk) disable iff (!cpurst_b)
    accept |-> $onehot(op_hit)
  ) else $error("accepted issue with unknown multiply opcode");

endmodule

// File: verilog/mult_array.sv
/* two-stage 65x65 signed multiplier, partial products at ex2
   and their sum at ex3 */

`timescale 1ns/1ps

module mult_array
  import mult_pkg::*;
(
  input  logic             mult_clk,
  input  logic             cpurst_b,
  input  logic             ex1_vld,
  input  logic             ex2_vld,
  input  logic [ext_w-1:0] src0_ex1,
  input  logic [ext_w-1:0] src1_ex1,
  output mult_prod_u       product
);

  // operands split as hi * 2^32 + lo, hi signed 33 bits
  logic signed [32:0] a_hi;
  logic signed [32:0] a_lo;
  logic signed [32:0] b_hi;
  logic signed [32:0] b_lo;

  logic signed [65:0] pp_hh;
  logic signed [65:0] pp_hl;
  logic signed [65:0] pp_lh;
  logic [63:0]        pp_ll;
  logic [prod_w-1:0]  sum_ex2;

  assign a_hi = src0_ex1[ext_w-1:32];
  assign b_hi = src1_ex1[ext_w-1:32];
  // low halves are magnitudes, zero on top
  assign a_lo = {1'b0, src0_ex1[31:0]};
  assign b_lo = {1'b0, src1_ex1[31:0]};

  // -------------------------------------------------
  // ex2 partial products
  // -------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      pp_hh <= '0;
      pp_hl <= '0;
      pp_lh <= '0;
      pp_ll <= '0;
    end else if (ex1_vld) begin
      pp_hh <= a_hi * b_hi;
      pp_hl <= a_hi * b_lo;
      pp_lh <= a_lo * b_hi;
      pp_ll <= src0_ex1[31:0] * src1_ex1[31:0];
    end
  end

  // -------------------------------------------------
  // ex3 sum
  // -------------------------------------------------
  // aligned and sign-extended to prod_w, bits above 127 dropped
  assign sum_ex2 = {pp_hh[63:0], 64'b0}
                 + {{30{pp_hl[65]}}, pp_hl, 32'b0}
                 + {{30{pp_lh[65]}}, pp_lh, 32'b0}
                 + {64'b0, pp_ll};

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      product <= '0;
    end else if (ex2_vld) begin
      product <= sum_ex2;
    end
  end

endmodule

// File: verilog/mult_stage_ctrl.sv
/* stage valids with flush and issue stall, and the tag pipeline
   from ex1 down to ex4 */

`timescale 1ns/1ps

module mult_stage_ctrl
  import mult_pkg::*;
(
  input  logic              mult_clk,
  input  logic              cpurst_b,
  input  logic              accept,
  input  logic              flush,
  input  logic [iid_w-1:0]  issue_iid,
  input  logic [preg_w-1:0] issue_preg,
  input  logic [dreg_w-1:0] dreg,
  input  logic [1:0]        rslt_sel,
  output logic              issue_stall,
  output logic              ex1_vld,
  output logic              ex2_vld,
  output logic              ex3_vld,
  output logic [preg_w-1:0] ex3_preg,
  output logic [1:0]        ex3_rslt_sel,
  output logic              ex4_vld,
  output logic [iid_w-1:0]  wb_iid,
  output logic [dreg_w-1:0] wb_dreg
);

  logic [iid_w-1:0]  ex1_iid;
  logic [preg_w-1:0] ex1_preg;
  logic [dreg_w-1:0] ex1_dreg;
  logic [1:0]        ex1_sel;
  logic [iid_w-1:0]  ex2_iid;
  logic [preg_w-1:0] ex2_preg;
  logic [dreg_w-1:0] ex2_dreg;
  logic [1:0]        ex2_sel;
  logic [iid_w-1:0]  ex3_iid;
  logic [dreg_w-1:0] ex3_dreg;

  // -------------------------------------------------
  // stage valids
  // -------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex1_vld <= 1'b0;
      ex2_vld <= 1'b0;
      ex3_vld <= 1'b0;
      ex4_vld <= 1'b0;
    end else if (flush) begin
      ex1_vld <= 1'b0;
      ex2_vld <= 1'b0;
      ex3_vld <= 1'b0;
      ex4_vld <= 1'b0;
    end else begin
      ex1_vld <= accept;
      ex2_vld <= ex1_vld;
      ex3_vld <= ex2_vld;
      ex4_vld <= ex3_vld;
    end
  end

  // ex1 busy, hold off the next issue
  assign issue_stall = ex1_vld;

  // -------------------------------------------------
  // tags, each stage loads from a valid predecessor
  // -------------------------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex1_iid  <= '0;
      ex1_preg <= '0;
      ex1_dreg <= '0;
      ex1_sel  <= '0;
    end else if (accept) begin
      ex1_iid  <= issue_iid;
      ex1_preg <= issue_preg;
      ex1_dreg <= dreg;
      ex1_sel  <= rslt_sel;
    end
  end

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex2_iid  <= '0;
      ex2_preg <= '0;
      ex2_dreg <= '0;
      ex2_sel  <= '0;
    end else if (ex1_vld) begin
      ex2_iid  <= ex1_iid;
      ex2_preg <= ex1_preg;
      ex2_dreg <= ex1_dreg;
      ex2_sel  <= ex1_sel;
    end
  end

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex3_iid      <= '0;
      ex3_preg     <= '0;
      ex3_dreg     <= '0;
      ex3_rslt_sel <= '0;
    end else if (ex2_vld) begin
      ex3_iid      <= ex2_iid;
      ex3_preg     <= ex2_preg;
      ex3_dreg     <= ex2_dreg;
      ex3_rslt_sel <= ex2_sel;
    end
  end

  // ex4 keeps only what writeback carries
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wb_iid  <= '0;
      wb_dreg <= '0;
    end else if (ex3_vld) begin
      wb_iid  <= ex3_iid;
      wb_dreg <= ex3_dreg;
    end
  end

  a_no_issue_in_stall: assert property (
    @(posedge mult_clk) disable iff (!cpurst_b)
    accept |-> !issue_stall
  ) else $error("issue accepted while ex1 is occupied");

  a_ex4_from_ex3: assert property (
    @(posedge mult_clk) disable iff (!cpurst_b)
    ex4_vld |-> $past(ex3_vld) && !$past(flush)
  ) else $error("ex4 valid without an unflushed ex3");

endmodule

// File: verilog/mult_result_sel.sv
/* ex4 product register and the 64-bit writeback select */

`timescale 1ns/1ps

module mult_result_sel
  import mult_pkg::*;
(
  input  logic            mult_clk,
  input  logic            cpurst_b,
  input  logic            ex3_vld,
  input  logic [1:0]      ex3_rslt_sel,
  input  mult_prod_u      product,
  output logic [xlen-1:0] wb_data
);

  mult_prod_u ex4_prod;
  logic [1:0] ex4_sel;

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex4_prod <= '0;
      ex4_sel  <= sel_lo64;
    end else if (ex3_vld) begin
      ex4_prod <= product;
      ex4_sel  <= ex3_rslt_sel;
    end
  end

  // -------------------------------------------------
  // doubleword view for 64-bit forms, word view for .w
  // -------------------------------------------------
  always_comb begin
    case (ex4_sel)
      sel_lo64: wb_data = ex4_prod.dw[0];
      sel_hi64: wb_data = ex4_prod.dw[1];
      sel_lo32: wb_data = {{32{ex4_prod.w[0][31]}}, ex4_prod.w[0]};
      default:  wb_data = {{32{ex4_prod.w[1][31]}}, ex4_prod.w[1]};
    endcase
  end

endmodule

// File: verilog/iu_mult.sv
/* multiply execution pipe top, ex1 to ex4, with operand prep,
   stage control, multiplier array and result select */

`timescale 1ns/1ps

module iu_mult
  import mult_pkg::*;
(
  input  logic              mult_clk,
  input  logic              cpurst_b,
  input  logic              flush,
  input  logic              issue_vld,
  input  logic [31:0]       issue_opcode,
  input  logic [iid_w-1:0]  issue_iid,
  input  logic [preg_w-1:0] issue_preg,
  input  logic [xlen-1:0]   issue_src0,
  input  logic [xlen-1:0]   issue_src1,
  output logic              issue_stall,
  output logic              ex3_data_vld,
  output logic [preg_w-1:0] ex3_preg,
  output logic              wb_vld,
  output logic [xlen-1:0]   wb_data,
  output logic [iid_w-1:0]  wb_iid,
  output logic [dreg_w-1:0] wb_dreg
);

  logic              accept;
  logic [ext_w-1:0]  src0_ex1;
  logic [ext_w-1:0]  src1_ex1;
  logic [dreg_w-1:0] dreg;
  logic [1:0]        rslt_sel;
  logic              ex1_vld;
  logic              ex2_vld;
  logic              ex3_vld;
  logic              ex4_vld;
  logic [1:0]        ex3_rslt_sel;
  mult_prod_u        product;

  // -------------------------------------------------
  // issue decode and ex1 operands
  // -------------------------------------------------
  mult_operand_prep u_prep (
    .mult_clk     (mult_clk),
    .cpurst_b     (cpurst_b),
    .issue_vld    (issue_vld),
    .flush        (flush),
    .issue_opcode (issue_opcode),
    .issue_src0   (issue_src0),
    .issue_src1   (issue_src1),
    .src0_ex1     (src0_ex1),
    .src1_ex1     (src1_ex1),
    .dreg         (dreg),
    .rslt_sel     (rslt_sel),
    .accept       (accept)
  );

  // valids and tags
  mult_stage_ctrl u_ctrl (
    .mult_clk     (mult_clk),
    .cpurst_b     (cpurst_b),
    .accept       (accept),
    .flush        (flush),
    .issue_iid    (issue_iid),
    .issue_preg   (issue_preg),
    .dreg         (dreg),
    .rslt_sel     (rslt_sel),
    .issue_stall  (issue_stall),
    .ex1_vld      (ex1_vld),
    .ex2_vld      (ex2_vld),
    .ex3_vld      (ex3_vld),
    .ex3_preg     (ex3_preg),
    .ex3_rslt_sel (ex3_rslt_sel),
    .ex4_vld      (ex4_vld),
    .wb_iid       (wb_iid),
    .wb_dreg      (wb_dreg)
  );

  // product ready at ex3
  mult_array u_array (
    .mult_clk (mult_clk),
    .cpurst_b (cpurst_b),
    .ex1_vld  (ex1_vld),
    .ex2_vld  (ex2_vld),
    .src0_ex1 (src0_ex1),
    .src1_ex1 (src1_ex1),
    .product  (product)
  );

  mult_result_sel u_rslt (
    .mult_clk     (mult_clk),
    .cpurst_b     (cpurst_b),
    .ex3_vld      (ex3_vld),
    .ex3_rslt_sel (ex3_rslt_sel),
    .product      (product),
    .wb_data      (wb_data)
  );

  // early wakeup one cycle ahead of writeback
  assign ex3_data_vld = ex3_vld;
  assign wb_vld       = ex4_vld;

endmodule

// File: tb/tb_iu_mult.sv
/* testbench for the multiply pipe: trace and random issues,
   wakeup and writeback checks, error counts */

`timescale 1ns/1ps

module tb_iu_mult
  import mult_pkg::*;
();

  localparam int drv_dly  = 2;
  localparam int n_random = 16;

  logic              mult_clk;
  logic              cpurst_b;
  logic              flush;
  logic              issue_vld;
  logic [31:0]       issue_opcode;
  logic [iid_w-1:0]  issue_iid;
  logic [preg_w-1:0] issue_preg;
  logic [xlen-1:0]   issue_src0;
  logic [xlen-1:0]   issue_src1;
  logic              issue_stall;
  logic              ex3_data_vld;
  logic [preg_w-1:0] ex3_preg;
  logic              wb_vld;
  logic [xlen-1:0]   wb_data;
  logic [iid_w-1:0]  wb_iid;
  logic [dreg_w-1:0] wb_dreg;

  // issue list, trace lines first and random ones after
  int                ent_op[$];
  logic [xlen-1:0]   ent_src0[$];
  logic [xlen-1:0]   ent_src1[$];
  logic [iid_w-1:0]  ent_iid[$];
  logic [preg_w-1:0] ent_preg[$];
  bit                ent_flush[$];
  logic [xlen-1:0]   ent_exp[$];

  // expected wakeups and writebacks, oldest first
  int                wake_tag_q[$];
  int                wake_edge_q[$];
  logic [preg_w-1:0] wake_preg_q[$];
  int                wb_tag_q[$];
  int                wb_edge_q[$];
  logic [iid_w-1:0]  wb_iid_q[$];
  logic [dreg_w-1:0] wb_dreg_q[$];
  logic [xlen-1:0]   wb_data_q[$];

  int          cyc;
  int          cyc_limit;
  int          chk_cnt;
  int          err_cnt;
  int          other_cnt;
  logic [31:0] lcg_state;
  string       op_names[8] = '{"mul.w", "mulh.w", "mulh.wu", "mul.d",
                               "mulh.d", "mulh.du", "mulw.d.w", "mulw.d.wu"};

  iu_mult i_dut (
    .mult_clk     (mult_clk),
    .cpurst_b     (cpurst_b),
    .flush        (flush),
    .issue_vld    (issue_vld),
    .issue_opcode (issue_opcode),
    .issue_iid    (issue_iid),
    .issue_preg   (issue_preg),
    .issue_src0   (issue_src0),
    .issue_src1   (issue_src1),
    .issue_stall  (issue_stall),
    .ex3_data_vld (ex3_data_vld),
    .ex3_preg     (ex3_preg),
    .wb_vld       (wb_vld),
    .wb_data      (wb_data),
    .wb_iid       (wb_iid),
    .wb_dreg      (wb_dreg)
  );

  initial begin
    mult_clk = 1'b0;
    forever #20 mult_clk = ~mult_clk;
  end

  // edge counter, also the run limit
  always @(posedge mult_clk) begin
    cyc = cyc + 1;
    if (cyc_limit > 0 && cyc > cyc_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cyc_limit);
      print_counts();
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int op_index(input string name);
    int k;
    for (k = 0; k < 8; k++) begin
      if (op_names[k] == name) return k;
    end
    return -1;
  endfunction

  // full product of the extended sources, then the slice the opcode wants
  function automatic logic [xlen-1:0] model_result(input int op,
                                                   input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
    logic [127:0] x;
    logic [127:0] y;
    logic [127:0] p;
    case (op)
      1, 6: begin
        x = {{96{a[31]}}, a[31:0]};
        y = {{96{b[31]}}, b[31:0]};
      end
      0, 2, 7: begin
        x = {96'b0, a[31:0]};
        y = {96'b0, b[31:0]};
      end
      3, 4: begin
        x = {{64{a[63]}}, a};
        y = {{64{b[63]}}, b};
      end
      default: begin
        x = {64'b0, a};
        y = {64'b0, b};
      end
    endcase
    p = x * y;
    case (op)
      0:       return {{32{p[31]}}, p[31:0]};
      1, 2:    return {{32{p[63]}}, p[63:32]};
      4, 5:    return p[127:64];
      default: return p[63:0];
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp_val,
                           input logic [63:0] act_val);
    chk_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic print_counts();
    $display("checks: %0d, value mismatches: %0d, other errors: %0d",
             chk_cnt, err_cnt, other_cnt);
  endtask

  task automatic add_entry(input int op, input logic [xlen-1:0] a,
                           input logic [xlen-1:0] b, input logic [iid_w-1:0] iid,
                           input logic [preg_w-1:0] preg, input bit fl,
                           input logic [xlen-1:0] exp_val);
    ent_op.push_back(op);
    ent_src0.push_back(a);
    ent_src1.push_back(b);
    ent_iid.push_back(iid);
    ent_preg.push_back(preg);
    ent_flush.push_back(fl);
    ent_exp.push_back(exp_val);
  endtask

  task automatic read_trace();
    int          fd;
    int          n;
    int          op;
    int          fl;
    string       line;
    string       name;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp_val;
    logic [7:0]  iid;
    logic [7:0]  preg;
    fd = $fopen("tb/mult_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tb/mult_trace.txt");
      other_cnt++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n  = $sscanf(line, "%s %h %h %h %h %d %h", name, a, b, iid, preg, fl, exp_val);
          op = op_index(name);
          if (n != 7 || op < 0) begin
            $display("trace line could not be read: %s", line);
            other_cnt++;
          end else begin
            add_entry(op, a, b, iid[6:0], preg[6:0], fl != 0, exp_val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic add_random_entries(input int count);
    int              k;
    int              op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    for (k = 0; k < count; k++) begin
      op = int'(next_rand() >> 29);
      a  = {next_rand(), next_rand()};
      b  = {next_rand(), next_rand()};
      add_entry(op, a, b, iid_w'(64 + k), preg_w'(96 + k), 1'b0, model_result(op, a, b));
    end
  endtask

  // a flush at edge f_edge kills ex1 to ex3, and ex4 loaded at that edge
  task automatic drop_flushed(input int f_edge);
    while (wake_edge_q.size() > 0 && wake_edge_q[$] + 3 >= f_edge) begin
      void'(wake_tag_q.pop_back());
      void'(wake_edge_q.pop_back());
      void'(wake_preg_q.pop_back());
    end
    while (wb_edge_q.size() > 0 && wb_edge_q[$] + 4 >= f_edge) begin
      void'(wb_tag_q.pop_back());
      void'(wb_edge_q.pop_back());
      void'(wb_iid_q.pop_back());
      void'(wb_dreg_q.pop_back());
      void'(wb_data_q.pop_back());
    end
  endtask

  // --------------------------------------------------
  // issue driver
  // --------------------------------------------------
  task automatic send_entry(input int i);
    int iss_edge;
    @(posedge mult_clk);
    #drv_dly;
    while (issue_stall) begin
      @(posedge mult_clk);
      #drv_dly;
    end
    issue_vld    = 1'b1;
    issue_opcode = {op_mul_w + op_w'(ent_op[i]), 10'h000, ent_iid[i][4:0]};
    issue_iid    = ent_iid[i];
    issue_preg   = ent_preg[i];
    issue_src0   = ent_src0[i];
    issue_src1   = ent_src1[i];
    // edge that opens the issue cycle, ex1 starts one edge later
    iss_edge     = cyc;
    wake_tag_q.push_back(i);
    wake_edge_q.push_back(iss_edge);
    wake_preg_q.push_back(ent_preg[i]);
    wb_tag_q.push_back(i);
    wb_edge_q.push_back(iss_edge);
    wb_iid_q.push_back(ent_iid[i]);
    wb_dreg_q.push_back(ent_iid[i][4:0]);
    wb_data_q.push_back(ent_exp[i]);
    @(posedge mult_clk);
    #drv_dly;
    issue_vld = 1'b0;
    check_val($sformatf("entry %0d stall after accept", i), 64'(1), 64'(issue_stall));
    if (ent_flush[i]) begin
      flush = 1'b1;
      drop_flushed(cyc + 1);
      @(posedge mult_clk);
      #drv_dly;
      flush = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // wakeup and writeback monitor
  // --------------------------------------------------
  always @(negedge mult_clk) begin
    if (cpurst_b) begin
      if (ex3_data_vld) begin
        if (wake_tag_q.size() == 0) begin
          $display("wakeup at cycle %0d with no issue in flight", cyc);
          other_cnt++;
        end else begin
          check_val($sformatf("entry %0d ex3_preg", wake_tag_q[0]),
                    64'(wake_preg_q[0]), 64'(ex3_preg));
          check_val($sformatf("entry %0d wakeup cycle", wake_tag_q[0]),
                    64'(wake_edge_q[0] + 3), 64'(cyc));
          void'(wake_tag_q.pop_front());
          void'(wake_edge_q.pop_front());
          void'(wake_preg_q.pop_front());
        end
      end
      if (wb_vld) begin
        if (wb_tag_q.size() == 0) begin
          $display("writeback at cycle %0d with no issue in flight", cyc);
          other_cnt++;
        end else begin
          check_val($sformatf("entry %0d wb_iid", wb_tag_q[0]), 64'(wb_iid_q[0]), 64'(wb_iid));
          check_val($sformatf("entry %0d wb_dreg", wb_tag_q[0]),
                    64'(wb_dreg_q[0]), 64'(wb_dreg));
          check_val($sformatf("entry %0d wb_data", wb_tag_q[0]), wb_data_q[0], wb_data);
          check_val($sformatf("entry %0d writeback cycle", wb_tag_q[0]),
                    64'(wb_edge_q[0] + 4), 64'(cyc));
          void'(wb_tag_q.pop_front());
          void'(wb_edge_q.pop_front());
          void'(wb_iid_q.pop_front());
          void'(wb_dreg_q.pop_front());
          void'(wb_data_q.pop_front());
        end
      end
    end
  end

  initial begin : main
    int i;
    cpurst_b     = 1'b0;
    flush        = 1'b0;
    issue_vld    = 1'b0;
    issue_opcode = '0;
    issue_iid    = '0;
    issue_preg   = '0;
    issue_src0   = '0;
    issue_src1   = '0;
    lcg_state    = 32'd39;
    read_trace();
    add_random_entries(n_random);
    // two cycles per issue plus flush gaps, reset and drain
    cyc_limit = 6 * ent_op.size() + 50 + 4;
    repeat (4) @(posedge mult_clk);
    #drv_dly;
    cpurst_b = 1'b1;
    check_val("reset issue_stall", 64'(0), 64'(issue_stall));
    check_val("reset ex3_data_vld", 64'(0), 64'(ex3_data_vld));
    check_val("reset wb_vld", 64'(0), 64'(wb_vld));
    for (i = 0; i < ent_op.size(); i++) begin
      send_entry(i);
    end
    while (wb_tag_q.size() > 0 || wake_tag_q.size() > 0) begin
      @(posedge mult_clk);
    end
    // quiet window, any late writeback shows up as an error
    repeat (6) @(posedge mult_clk);
    print_counts();
    if (err_cnt == 0 && other_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb/mult_trace.txt
# columns: opcode src0 src1 iid preg flush expected, all hex except flush
# a flush line also kills the issue before it, which is still in flight
mul.w      0000000000000003 0000000000000005 01 21 0 000000000000000f
mul.w      000000007fffffff 0000000000000002 02 22 0 fffffffffffffffe
mul.w      ffffffffffffffff 1234567800000003 03 23 0 fffffffffffffffd
mulh.w     0000000080000000 0000000080000000 04 24 0 0000000040000000
mulh.w     ffffffffffffffff 0000000000000002 05 25 0 ffffffffffffffff
mulh.wu    00000000ffffffff 00000000ffffffff 06 26 0 fffffffffffffffe
mulh.wu    0000000000010000 0000000000010000 07 27 0 0000000000000001
mul.d      0000000100000001 0000000000000003 08 28 0 0000000300000003
mul.d      8000000000000000 ffffffffffffffff 09 29 0 8000000000000000
mul.d      ffffffffffffffff ffffffffffffffff 0a 2a 0 0000000000000001
mulh.d     8000000000000000 8000000000000000 0b 2b 0 4000000000000000
mulh.d     ffffffffffffffff 0000000000000005 0c 2c 0 ffffffffffffffff
mulh.d     7fffffffffffffff 7fffffffffffffff 0d 2d 0 3fffffffffffffff
mulh.du    ffffffffffffffff ffffffffffffffff 0e 2e 0 fffffffffffffffe
mulh.du    8000000000000000 0000000000000002 0f 2f 0 0000000000000001
mulw.d.w   12345678ffffffff abcdef0100000007 10 30 0 fffffffffffffff9
mulw.d.w   0000000080000000 0000000080000000 11 31 0 4000000000000000
mulw.d.wu  00000000ffffffff 00000000ffffffff 12 32 0 fffffffe00000001
mulw.d.wu  0000000080000000 0000000000000002 13 33 0 0000000100000000
mul.d      0000000000000002 0000000000000002 14 34 0 0000000000000004
mul.d      0000000000000005 0000000000000007 15 35 1 0000000000000023
mul.w      0000000000000006 0000000000000007 16 36 0 000000000000002a
mul.d      0000000000000000 ffffffffffffffff 17 37 0 0000000000000000

// File: iu_mult.f
verilog/mult_pkg.sv
verilog/mult_operand_prep.sv
verilog/mult_array.sv
verilog/mult_stage_ctrl.sv
verilog/mult_result_sel.sv
verilog/iu_mult.sv
tb/tb_iu_mult.sv

// File: Makefile
# Verilator build and run of the multiply pipe testbench

VERILATOR ?= verilator
TOP       ?= tb_iu_mult
FILELIST  ?= iu_mult.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
